/* bench/ccl_ref.svh */
// raster labeling model that works on the bench image array and uses the bench size constants
`ifndef CCL_REF_SVH
`define CCL_REF_SVH

int lab_map  [H][W];   // label given to each pixel
int root_map [H][W];   // smallest label of the connected region
int ref_count;
int ref_overflow;
int ref_requests;
int ref_area [NL];
int ref_xmin [NL];
int ref_xmax [NL];
int ref_ymin [NL];
int ref_ymax [NL];

// expected labels, roots, areas, boxes and request count for the current image
function automatic void compute_ref();
    int  left;
    int  above;
    int  c;
    int  m;
    int  r;
    bit  changed;
    ref_count    = 0;
    ref_overflow = 0;
    ref_requests = 0;
    for (int y = 0; y < H; y++) begin
        for (int x = 0; x < W; x++) begin
            left  = (x > 0) ? lab_map[y][x-1] : 0;
            above = (y > 0) ? lab_map[y-1][x] : 0;
            if (!img[y][x]) begin
                c = 0;
            end else if (left == 0 && above == 0) begin
                if (ref_count == NL - 1) begin
                    ref_overflow = 1;   // out of labels, pixel dropped
                    c = 0;
                end else begin
                    ref_count = ref_count + 1;
                    c = ref_count;
                end
            end else if (left == 0) begin
                c = above;
            end else if (above == 0) begin
                c = left;
            end else begin
                c = (left < above) ? left : above;
                if (left != above) ref_requests = ref_requests + 1;
            end
            lab_map[y][x]  = c;
            root_map[y][x] = c;
        end
    end
    // spread the region minimum until stable
    do begin
        changed = 1'b0;
        for (int y = 0; y < H; y++) begin
            for (int x = 0; x < W; x++) begin
                if (lab_map[y][x] != 0) begin
                    m = root_map[y][x];
                    if (x > 0 && lab_map[y][x-1] != 0 && root_map[y][x-1] < m)
                        m = root_map[y][x-1];
                    if (x < W - 1 && lab_map[y][x+1] != 0 && root_map[y][x+1] < m)
                        m = root_map[y][x+1];
                    if (y > 0 && lab_map[y-1][x] != 0 && root_map[y-1][x] < m)
                        m = root_map[y-1][x];
                    if (y < H - 1 && lab_map[y+1][x] != 0 && root_map[y+1][x] < m)
                        m = root_map[y+1][x];
                    if (m < root_map[y][x]) begin
                        root_map[y][x] = m;
                        changed = 1'b1;
                    end
                end
            end
        end
    end while (changed);
    for (int l = 0; l < NL; l++) begin
        ref_area[l] = 0;
        ref_xmin[l] = 0;
        ref_xmax[l] = 0;
        ref_ymin[l] = 0;
        ref_ymax[l] = 0;
    end
    for (int y = 0; y < H; y++) begin
        for (int x = 0; x < W; x++) begin
            if (lab_map[y][x] != 0) begin
                r = root_map[y][x];   // totals live at the root only
                if (ref_area[r] == 0) begin
                    ref_xmin[r] = x;
                    ref_xmax[r] = x;
                    ref_ymin[r] = y;
                    ref_ymax[r] = y;
                end else begin
                    if (x < ref_xmin[r]) ref_xmin[r] = x;
                    if (x > ref_xmax[r]) ref_xmax[r] = x;
                    if (y < ref_ymin[r]) ref_ymin[r] = y;
                    if (y > ref_ymax[r]) ref_ymax[r] = y;
                end
                ref_area[r] = ref_area[r] + 1;
            end
        end
    end
endfunction

// box word with ymax in the top byte down to xmin
function automatic logic [31:0] ref_box(int l);
    if (ref_area[l] == 0) return 32'h0;
    return {8'(ref_ymax[l]), 8'(ref_xmax[l]), 8'(ref_ymin[l]), 8'(ref_xmin[l])};
endfunction

`endif

/* bench/ccl_tb.sv */
// single clock bench, results are read over axi4-lite only after the done bit is seen
`default_nettype none

`include "ccl_settings.svh"

module ccl_tb;
    localparam int     W          = `CCL_IMG_WIDTH;
    localparam int     H          = `CCL_IMG_HEIGHT;
    localparam int     NL         = `CCL_MAX_LABELS;
    localparam int     PERIOD     = 40;
    localparam int     DRIVE_DLY  = 5;    // after the rising edge
    localparam int     LINE_GAP   = 4;
    localparam int     NUM_FRAMES = 11;
    localparam int     FRAME_CYC  = W * H + H * LINE_GAP + 64 * NL;
    localparam longint TIMEOUT    = longint'(NUM_FRAMES + 2) * FRAME_CYC * PERIOD;

    logic        clk;
    logic        reset;
    logic        frame_active;
    logic        line_valid;
    logic        pixel;
    logic [11:0] araddr;
    logic        arvalid;
    logic        rready;
    wire         arready;
    wire  [31:0] rdata;
    wire  [1:0]  rresp;
    wire         rvalid;

    integer      seed;
    logic        img [H][W];
    logic [31:0] got;

    `include "ccl_ref.svh"

    ccl_top u_ccl_top (
        .clk(clk), .reset(reset), .frame_active_i(frame_active),
        .line_valid_i(line_valid), .pixel_i(pixel),
        .s_axil_araddr_i(araddr), .s_axil_arvalid_i(arvalid), .s_axil_rready_i(rready),
        .s_axil_arready_o(arready), .s_axil_rdata_o(rdata), .s_axil_rresp_o(rresp),
        .s_axil_rvalid_o(rvalid)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic step();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        if (act !== exp) begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, act, exp);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one read, rready held low for stall cycles once data is valid
    task automatic axi_read(input logic [11:0] addr, input int stall, output logic [31:0] data);
        araddr  = addr;
        arvalid = 1'b1;
        step();
        while (!rvalid) step();
        arvalid = 1'b0;
        data = rdata;
        check_value("rresp", 32'(rresp), 32'h0);
        check_value("arready", 32'(arready), 32'h0);
        for (int i = 0; i < stall; i++) begin
            step();
            check_value("rvalid", 32'(rvalid), 32'h1);
            check_value("arready", 32'(arready), 32'h0);
            check_value("rdata", rdata, data);   // held under back-pressure
        end
        rready = 1'b1;
        step();
        rready = 1'b0;
        check_value("rvalid", 32'(rvalid), 32'h0);
        check_value("arready", 32'(arready), 32'h1);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        st = '0;
        while (!st[0]) axi_read(12'h000, 0, st);
    endtask

    task automatic drive_frame();
        frame_active = 1'b1;
        step();
        step();   // first pixel well after frame start
        for (int y = 0; y < H; y++) begin
            for (int x = 0; x < W; x++) begin
                line_valid = 1'b1;
                pixel      = img[y][x];
                step();
            end
            line_valid = 1'b0;
            pixel      = 1'b0;
            repeat (LINE_GAP) step();
        end
        frame_active = 1'b0;
        step();
    endtask

    task automatic clear_image();
        for (int y = 0; y < H; y++)
            for (int x = 0; x < W; x++)
                img[y][x] = 1'b0;
    endtask

    task automatic draw_box(input int x0, input int x1, input int y0, input int y1);
        for (int y = y0; y <= y1; y++)
            for (int x = x0; x <= x1; x++)
                img[y][x] = 1'b1;
    endtask

    task automatic fill_random();
        for (int y = 0; y < H; y++)
            for (int x = 0; x < W; x++)
                img[y][x] = ($random(seed) & 15) == 0;   // sparse
    endtask

    task automatic fill_checker();
        for (int y = 0; y < H; y++)
            for (int x = 0; x < W; x++)
                img[y][x] = ((x + y) & 1) == 0;
    endtask

    // compares status and every table entry against the reference
    task automatic compare_frame();
        logic [31:0] act;
        logic [31:0] exp_status;
        int          stall;
        compute_ref();
        wait_done();
        check_value("ref_requests_below_depth", 32'(ref_requests < `CCL_FIFO_DEPTH), 32'h1);
        exp_status = {16'h0, 8'(ref_count), 5'h0, 1'b0, ref_overflow[0], 1'b1};
        axi_read(12'h000, 0, act);
        check_value("status", act, exp_status);
        for (int l = 0; l < NL; l++) begin
            stall = $unsigned($random(seed)) % 4;
            axi_read(12'(12'h100 + 8 * l), stall, act);
            check_value($sformatf("area[%0d]", l), act, 32'(ref_area[l]));
            stall = $unsigned($random(seed)) % 4;
            axi_read(12'(12'h104 + 8 * l), stall, act);
            check_value($sformatf("bbox[%0d]", l), act, ref_box(l));
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        frame_active = 1'b0;
        line_valid   = 1'b0;
        pixel        = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        seed         = 32'hf647_ae64;
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;
        step();
        axi_read(12'h000, 0, got);
        check_value("status", got, 32'h0);
        axi_read(12'h004, 2, got);   // unmapped
        check_value("unmapped", got, 32'h0);

        clear_image();
        draw_box(5, 14, 3, 9);
        drive_frame();
        compare_frame();
        check_value("rect_label_count", 32'(ref_count), 32'd1);
        check_value("rect_area", 32'(ref_area[1]), 32'd70);

        clear_image();
        draw_box(4, 7, 2, 13);   // left arm
        draw_box(20, 23, 2, 13); // right arm
        draw_box(4, 23, 12, 13); // joining bottom
        drive_frame();
        compare_frame();
        check_value("u_label_count", 32'(ref_count), 32'd2);
        check_value("u_area2", 32'(ref_area[2]), 32'd0);

        for (int f = 0; f < 8; f++) begin
            fill_random();
            drive_frame();
            compare_frame();
        end

        fill_checker();
        drive_frame();
        compare_frame();
        check_value("checker_label_count", 32'(ref_count), 32'd63);
        check_value("checker_overflow", 32'(ref_overflow), 32'd1);

        $display("TEST PASS");
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog expired before all frames were checked");
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* ccl_top.f */
+incdir+common
+incdir+bench
common/ccl_pkg.sv
logic/union_fifo.sv
logic/component_stats.sv
logic/axil_result_port.sv
labeling/label_assign.sv
labeling/union_find.sv
labeling/merge_ctrl.sv
logic/ccl_top.sv
bench/ccl_tb.sv

/* common/ccl_pkg.sv */
// shared label and result types where coordinates are limited to 8 bits
`default_nettype none

`include "ccl_settings.svh"

package ccl_pkg;

    typedef logic [`CCL_LABEL_W-1:0] label_t;
    typedef logic [7:0]              coord_t;
    typedef logic [15:0]             area_t;

    // bounding box as one bus word or as four byte fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            coord_t ymax;   // top byte
            coord_t xmax;
            coord_t ymin;
            coord_t xmin;
        } f;
    } bbox_u;

endpackage

`default_nettype wire

/* common/ccl_settings.svh */
// image width must fit in 8 bit coordinates and the fifo depth must be a power of two
`ifndef CCL_SETTINGS_SVH
`define CCL_SETTINGS_SVH

`define CCL_IMG_WIDTH   32      // pixels per line
`define CCL_IMG_HEIGHT  16      // lines per frame

// label 0 is background so 63 labels are usable
`define CCL_MAX_LABELS  64
`define CCL_LABEL_W     6

`define CCL_FIFO_DEPTH  32      // union request entries

`endif

/* labeling/label_assign.sv */
// first pixel of a frame must come at least one cycle after frame_active rises
`default_nettype none

`include "ccl_settings.svh"

module label_assign import ccl_pkg::*; (
    input  wire    clk,
    input  wire    reset,
    input  wire    frame_active_i,
    input  wire    line_valid_i,
    input  wire    pixel_i,
    output logic   frame_start_o,
    output logic   frame_end_o,
    output logic   upd_valid_o,
    output logic   upd_new_o,
    output label_t upd_label_o,
    output coord_t upd_x_o,
    output coord_t upd_y_o,
    output logic   push_o,
    output label_t push_a_o,
    output label_t push_b_o,
    output label_t label_count_o,
    output logic   label_overflow_o
);
    localparam int     XW     = $clog2(`CCL_IMG_WIDTH);
    localparam coord_t LAST_X = coord_t'(`CCL_IMG_WIDTH - 1);

    logic   fa_q;
    coord_t x_q, y_q;
    label_t left_q, left, above, cur;
    label_t lbuf [`CCL_IMG_WIDTH];   // labels of the line above
    logic   need_new, exhausted, is_new, in_frame;

    wire start = frame_active_i & ~fa_q;

    always_comb begin
        in_frame  = line_valid_i && (y_q < coord_t'(`CCL_IMG_HEIGHT));
        left      = (x_q == '0) ? '0 : left_q;
        above     = (y_q == '0) ? '0 : lbuf[x_q[XW-1:0]];
        need_new  = pixel_i && left == '0 && above == '0;
        exhausted = label_count_o == label_t'(`CCL_MAX_LABELS - 1);
        is_new    = need_new && !exhausted;
        if (!pixel_i || (need_new && exhausted))
            cur = '0;                           // background or out of labels
        else if (need_new)
            cur = label_count_o + 1'b1;
        else if (left == '0 || (above != '0 && above < left))
            cur = above;
        else
            cur = left;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fa_q             <= 1'b0;
            frame_start_o    <= 1'b0;
            frame_end_o      <= 1'b0;
            upd_valid_o      <= 1'b0;
            push_o           <= 1'b0;
            x_q              <= '0;
            y_q              <= '0;
            label_count_o    <= '0;
            label_overflow_o <= 1'b0;
        end else begin
            fa_q          <= frame_active_i;
            frame_start_o <= start;
            frame_end_o   <= ~frame_active_i & fa_q;
            upd_valid_o   <= in_frame && cur != '0;
            push_o        <= in_frame && pixel_i && left != '0 && above != '0 && left != above;
            if (start) begin
                x_q              <= '0;
                y_q              <= '0;
                label_count_o    <= '0;
                label_overflow_o <= 1'b0;
            end else if (in_frame) begin
                if (x_q == LAST_X) begin
                    x_q <= '0;
                    y_q <= y_q + 1'b1;
                end else begin
                    x_q <= x_q + 1'b1;
                end
                if (is_new) label_count_o <= cur;
                if (need_new && exhausted) label_overflow_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_frame) begin
            lbuf[x_q[XW-1:0]] <= cur;
            left_q            <= cur;
        end
        upd_new_o   <= is_new;
        upd_label_o <= cur;
        upd_x_o     <= x_q;
        upd_y_o     <= y_q;
        push_a_o    <= left;
        push_b_o    <= above;
    end

endmodule

`default_nettype wire

/* labeling/merge_ctrl.sv */
// fold strobes are combinational so they land on the same edge that raises done
`default_nettype none

module merge_ctrl import ccl_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire         frame_start_i,
    input  wire         frame_end_i,
    input  wire         fifo_empty_i,
    input  wire         uf_idle_i,
    input  wire         root_valid_i,
    input  wire label_t root_i,
    input  wire label_t label_count_i,
    output logic        find_valid_o,
    output label_t      find_label_o,
    output logic        fold_valid_o,
    output label_t      fold_child_o,
    output label_t      fold_root_o,
    output logic        done_o
);
    localparam logic [2:0] M_IDLE  = 3'd0;
    localparam logic [2:0] M_DRAIN = 3'd1;
    localparam logic [2:0] M_FIND  = 3'd2;
    localparam logic [2:0] M_WAIT  = 3'd3;
    localparam logic [2:0] M_DONE  = 3'd4;

    logic [2:0] state_q;
    label_t     cur_q;

    assign find_valid_o = state_q == M_FIND && uf_idle_i;
    assign find_label_o = cur_q;
    assign fold_valid_o = state_q == M_WAIT && root_valid_i && root_i != cur_q;
    assign fold_child_o = cur_q;
    assign fold_root_o  = root_i;
    assign done_o       = state_q == M_DONE;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= M_IDLE;
            cur_q   <= '0;
        end else if (frame_start_i) begin
            state_q <= M_IDLE;
        end else begin
            case (state_q)
                M_IDLE: if (frame_end_i) state_q <= M_DRAIN;
                M_DRAIN: begin
                    // pending unions must settle first
                    if (fifo_empty_i && uf_idle_i) begin
                        cur_q   <= label_t'(1);
                        state_q <= (label_count_i == '0) ? M_DONE : M_FIND;
                    end
                end
                M_FIND: if (uf_idle_i) state_q <= M_WAIT;
                M_WAIT: begin
                    if (root_valid_i) begin
                        cur_q   <= cur_q + 1'b1;
                        state_q <= (cur_q == label_count_i) ? M_DONE : M_FIND;
                    end
                end
                M_DONE:  state_q <= M_DONE;   // held until next frame
                default: state_q <= M_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* labeling/union_find.sv */
// one operation at a time and a find takes priority over a queued union
`default_nettype none

`include "ccl_settings.svh"

module union_find import ccl_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire         frame_start_i,
    input  wire         pop_valid_i,
    input  wire label_t pop_a_i,
    input  wire label_t pop_b_i,
    input  wire         find_valid_i,
    input  wire label_t find_label_i,
    output logic        pop_ready_o,
    output logic        idle_o,
    output logic        root_valid_o,
    output label_t      root_o
);
    localparam int         N       = `CCL_MAX_LABELS;
    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_UNION = 2'd1;
    localparam logic [1:0] S_FIND  = 2'd2;

    label_t     parent [N];
    label_t     node_a, node_b, par_a, par_b;
    logic [1:0] state_q;
    logic       a_root, b_root;

    assign par_a       = parent[node_a];
    assign par_b       = parent[node_b];
    assign a_root      = par_a == node_a;
    assign b_root      = par_b == node_b;
    assign idle_o      = state_q == S_IDLE;
    assign pop_ready_o = idle_o && !find_valid_i;
    assign root_o      = node_a;   // holds the root after a find

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q      <= S_IDLE;
            root_valid_o <= 1'b0;
            node_a       <= '0;
            node_b       <= '0;
            for (int i = 0; i < N; i++) parent[i] <= label_t'(i);
        end else if (frame_start_i) begin
            state_q      <= S_IDLE;
            root_valid_o <= 1'b0;
            for (int i = 0; i < N; i++) parent[i] <= label_t'(i);   // every label its own root
        end else begin
            root_valid_o <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (find_valid_i) begin
                        node_a  <= find_label_i;
                        state_q <= S_FIND;
                    end else if (pop_valid_i) begin
                        node_a  <= pop_a_i;
                        node_b  <= pop_b_i;
                        state_q <= S_UNION;
                    end
                end
                S_UNION: begin
                    if (!a_root) node_a <= par_a;   // both walk in parallel
                    if (!b_root) node_b <= par_b;
                    if (a_root && b_root) begin
                        if (node_a < node_b) parent[node_b] <= node_a;
                        else if (node_b < node_a) parent[node_a] <= node_b;
                        state_q <= S_IDLE;
                    end
                end
                S_FIND: begin
                    if (a_root) begin
                        root_valid_o <= 1'b1;
                        state_q      <= S_IDLE;
                    end else begin
                        node_a <= par_a;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/axil_result_port.sv */
// read only slave with one outstanding read and rresp always okay
`default_nettype none

`include "ccl_settings.svh"

module axil_result_port import ccl_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire  [11:0] araddr_i,
    input  wire         arvalid_i,
    input  wire         rready_i,
    input  wire         done_i,
    input  wire         label_overflow_i,
    input  wire         fifo_overflow_i,
    input  wire label_t label_count_i,
    input  wire area_t  rd_area_i,
    input  wire bbox_u  rd_bbox_i,
    output logic        arready_o,
    output logic [31:0] rdata_o,
    output logic [1:0]  rresp_o,
    output logic        rvalid_o,
    output label_t      rd_label_o
);
    localparam logic [11:0] TABLE_BASE = 12'h100;
    localparam int          TABLE_SPAN = 8 * `CCL_MAX_LABELS;   // two words per label

    logic [11:0] offs;
    logic [31:0] rd_word;

    assign offs       = araddr_i - TABLE_BASE;
    assign rd_label_o = offs[3 +: `CCL_LABEL_W];
    assign arready_o  = !rvalid_o;
    assign rresp_o    = 2'b00;

    always_comb begin
        rd_word = '0;
        if (araddr_i == 12'h000) begin
            rd_word = {16'b0, 8'(label_count_i), 5'b0,
                       fifo_overflow_i, label_overflow_i, done_i};
        end else if (araddr_i >= TABLE_BASE && offs < 12'(TABLE_SPAN) && offs[1:0] == 2'b00) begin
            rd_word = offs[2] ? rd_bbox_i.raw : {16'b0, rd_area_i};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rvalid_o <= 1'b0;
        end else if (arvalid_i && arready_o) begin
            rvalid_o <= 1'b1;
        end else if (rvalid_o && rready_i) begin
            rvalid_o <= 1'b0;
        end
    end

    // data held while rready is low
    always_ff @(posedge clk) begin
        if (arvalid_i && arready_o) rdata_o <= rd_word;
    end

endmodule

`default_nettype wire

/* logic/ccl_top.sv */
// results are only valid while status done is set and read back through axi4-lite only
`default_nettype none

module ccl_top import ccl_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire         frame_active_i,
    input  wire         line_valid_i,
    input  wire         pixel_i,
    input  wire  [11:0] s_axil_araddr_i,
    input  wire         s_axil_arvalid_i,
    input  wire         s_axil_rready_i,
    output wire         s_axil_arready_o,
    output wire  [31:0] s_axil_rdata_o,
    output wire  [1:0]  s_axil_rresp_o,
    output wire         s_axil_rvalid_o
);
    wire         frame_start, frame_end;
    wire         upd_valid, upd_new;
    wire label_t upd_label;
    wire coord_t upd_x, upd_y;
    wire         push;
    wire label_t push_a, push_b;
    wire label_t label_count;
    wire         label_overflow;
    wire         pop_valid, pop_ready, fifo_empty, fifo_overflow;
    wire label_t pop_a, pop_b;
    wire         uf_idle, root_valid, find_valid;
    wire label_t root, find_label;
    wire         fold_valid, done;
    wire label_t fold_child, fold_root;
    wire label_t rd_label;
    wire area_t  rd_area;
    wire bbox_u  rd_bbox;

    label_assign u_label_assign (
        .clk, .reset, .frame_active_i, .line_valid_i, .pixel_i,
        .frame_start_o(frame_start), .frame_end_o(frame_end),
        .upd_valid_o(upd_valid), .upd_new_o(upd_new), .upd_label_o(upd_label),
        .upd_x_o(upd_x), .upd_y_o(upd_y),
        .push_o(push), .push_a_o(push_a), .push_b_o(push_b),
        .label_count_o(label_count), .label_overflow_o(label_overflow)
    );

    union_fifo u_union_fifo (
        .clk, .reset, .clear_i(frame_start),
        .push_i(push), .push_a_i(push_a), .push_b_i(push_b),
        .pop_ready_i(pop_ready), .pop_valid_o(pop_valid), .pop_a_o(pop_a), .pop_b_o(pop_b),
        .empty_o(fifo_empty), .fifo_overflow_o(fifo_overflow)
    );

    union_find u_union_find (
        .clk, .reset, .frame_start_i(frame_start),
        .pop_valid_i(pop_valid), .pop_a_i(pop_a), .pop_b_i(pop_b),
        .find_valid_i(find_valid), .find_label_i(find_label),
        .pop_ready_o(pop_ready), .idle_o(uf_idle), .root_valid_o(root_valid), .root_o(root)
    );

    merge_ctrl u_merge_ctrl (
        .clk, .reset, .frame_start_i(frame_start), .frame_end_i(frame_end),
        .fifo_empty_i(fifo_empty), .uf_idle_i(uf_idle), .root_valid_i(root_valid),
        .root_i(root), .label_count_i(label_count),
        .find_valid_o(find_valid), .find_label_o(find_label), .fold_valid_o(fold_valid),
        .fold_child_o(fold_child), .fold_root_o(fold_root), .done_o(done)
    );

    component_stats u_component_stats (
        .clk, .reset, .frame_start_i(frame_start),
        .upd_valid_i(upd_valid), .upd_new_i(upd_new), .upd_label_i(upd_label),
        .upd_x_i(upd_x), .upd_y_i(upd_y),
        .fold_valid_i(fold_valid), .fold_child_i(fold_child), .fold_root_i(fold_root),
        .rd_label_i(rd_label), .rd_area_o(rd_area), .rd_bbox_o(rd_bbox)
    );

    axil_result_port u_axil_result_port (
        .clk, .reset, .araddr_i(s_axil_araddr_i), .arvalid_i(s_axil_arvalid_i),
        .rready_i(s_axil_rready_i), .done_i(done), .label_overflow_i(label_overflow),
        .fifo_overflow_i(fifo_overflow), .label_count_i(label_count),
        .rd_area_i(rd_area), .rd_bbox_i(rd_bbox),
        .arready_o(s_axil_arready_o), .rdata_o(s_axil_rdata_o), .rresp_o(s_axil_rresp_o),
        .rvalid_o(s_axil_rvalid_o), .rd_label_o(rd_label)
    );

endmodule

`default_nettype wire

/* logic/component_stats.sv */
// updates and folds never arrive together and a fold child must differ from its root
`default_nettype none

`include "ccl_settings.svh"

module component_stats import ccl_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire         frame_start_i,
    input  wire         upd_valid_i,
    input  wire         upd_new_i,
    input  wire label_t upd_label_i,
    input  wire coord_t upd_x_i,
    input  wire coord_t upd_y_i,
    input  wire         fold_valid_i,
    input  wire label_t fold_child_i,
    input  wire label_t fold_root_i,
    input  wire label_t rd_label_i,
    output area_t       rd_area_o,
    output bbox_u       rd_bbox_o
);
    localparam int N = `CCL_MAX_LABELS;

    area_t area_q [N];
    bbox_u box_q  [N];
    bbox_u pix_box;

    // smallest box holding both
    function automatic bbox_u box_union(bbox_u a, bbox_u b);
        bbox_u r;
        r.f.xmin = (a.f.xmin < b.f.xmin) ? a.f.xmin : b.f.xmin;
        r.f.ymin = (a.f.ymin < b.f.ymin) ? a.f.ymin : b.f.ymin;
        r.f.xmax = (a.f.xmax > b.f.xmax) ? a.f.xmax : b.f.xmax;
        r.f.ymax = (a.f.ymax > b.f.ymax) ? a.f.ymax : b.f.ymax;
        return r;
    endfunction

    assign pix_box   = {upd_y_i, upd_x_i, upd_y_i, upd_x_i};   // single pixel box
    assign rd_area_o = area_q[rd_label_i];
    assign rd_bbox_o = box_q[rd_label_i];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < N; i++) begin
                area_q[i] <= '0;
                box_q[i]  <= '0;
            end
        end else if (frame_start_i) begin
            for (int i = 0; i < N; i++) begin
                area_q[i] <= '0;
                box_q[i]  <= '0;
            end
        end else if (upd_valid_i) begin
            if (upd_new_i) begin
                area_q[upd_label_i] <= area_t'(1);
                box_q[upd_label_i]  <= pix_box;
            end else begin
                area_q[upd_label_i] <= area_q[upd_label_i] + 1'b1;
                box_q[upd_label_i]  <= box_union(box_q[upd_label_i], pix_box);
            end
        end else if (fold_valid_i) begin
            area_q[fold_root_i]  <= area_q[fold_root_i] + area_q[fold_child_i];
            box_q[fold_root_i]   <= box_union(box_q[fold_root_i], box_q[fold_child_i]);
            area_q[fold_child_i] <= '0;   // child now reads empty
            box_q[fold_child_i]  <= '0;
        end
    end

endmodule

`default_nettype wire

/* logic/union_fifo.sv */
// depth must be a power of two and pushes into a full buffer are dropped
`default_nettype none

`include "ccl_settings.svh"

module union_fifo import ccl_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire         clear_i,
    input  wire         push_i,
    input  wire label_t push_a_i,
    input  wire label_t push_b_i,
    input  wire         pop_ready_i,
    output logic        pop_valid_o,
    output label_t      pop_a_o,
    output label_t      pop_b_o,
    output logic        empty_o,
    output logic        fifo_overflow_o
);
    localparam int DEPTH = `CCL_FIFO_DEPTH;
    localparam int PW    = $clog2(DEPTH);

    label_t          mem_a [DEPTH];
    label_t          mem_b [DEPTH];
    logic [PW-1:0]   wr_ptr, rd_ptr;
    logic [PW:0]     count;
    logic            do_push, do_pop;

    assign do_push     = push_i && count != (PW+1)'(DEPTH);
    assign do_pop      = pop_valid_o && pop_ready_i;
    assign pop_valid_o = count != '0;
    assign empty_o     = count == '0;
    assign pop_a_o     = mem_a[rd_ptr];
    assign pop_b_o     = mem_b[rd_ptr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            count           <= '0;
            fifo_overflow_o <= 1'b0;
        end else if (clear_i) begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            count           <= '0;
            fifo_overflow_o <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // pointers wrap naturally
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PW+1)'(do_push) - (PW+1)'(do_pop);
            if (push_i && !do_push) fifo_overflow_o <= 1'b1;   // sticky
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_a[wr_ptr] <= push_a_i;
            mem_b[wr_ptr] <= push_b_i;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module ccl_tb -f ccl_top.f -o ccl_sim \
    && { ./obj_dir/ccl_sim > sim.log 2>&1 || true; } \
    && cat sim.log \
    && grep -qx "TEST PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
